// File: dv/riscv64_props.sv
`timescale 1ns/1ps

module riscv64_props (
    input logic                 clk,
    input logic                 reset,
    input rv_bus_pkg::bus_req_t bus_req,
    input logic                 interrupt_done
);
    // failure tally, summed into the testbench result
    int violations = 0;

    // uart write only right after the keyboard read
    write_after_read: assert property (@(posedge clk) disable iff (!reset)
        bus_req.write_enable |-> $past(bus_req.read_enable))
    else begin
        violations++;
        $error("bus write without a read one cycle earlier");
    end

    // one access per cycle
    no_read_write_overlap: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable))
    else begin
        violations++;
        $error("bus read and write enables high together");
    end

    // done pulse is the write strobe
    done_is_write: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done == bus_req.write_enable)
    else begin
        violations++;
        $error("interrupt_done out of step with the bus write");
    end

endmodule

bind rv_irq_sequencer riscv64_props props_inst (
    .clk            (clk),
    .reset          (reset),
    .bus_req        (bus_req),
    .interrupt_done (interrupt_done)
);

// File: dv/riscv64_tb.sv
`timescale 1ns/1ps

module riscv64_tb;
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    // non-zero vectors so a wrong redirect shows up
    localparam logic [31:0] tb_reset_pc = 32'h0000_1000;
    localparam logic [31:0] tb_trap_pc  = 32'h0000_0200;

    logic        clk;
    logic        reset;
    inst_t       instruction;
    logic [3:0]  interrupt_vector;
    xlen_t       bus_read_data;
    reg_idx_t    dbg_addr;
    logic [31:0] pc;
    logic [31:0] ir;
    logic        heartbeat;
    logic        interrupt_done;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    xlen_t       dbg_data;

    // architectural model, values for the current cycle
    xlen_t       m_regs [0:31];
    logic [31:0] m_pc;
    logic [31:0] m_ir;
    logic        m_hb;
    logic        m_bubble;
    logic        m_read;
    logic        m_write;
    xlen_t       m_wdata;

    // keyboard data register, new value every cycle
    xlen_t       key_reg;
    integer      seed;
    int          errors;
    int          test_base;
    int          tests_run;
    int          tests_failed;
    int          reads_seen;
    int          writes_seen;
    logic        last_done;
    logic        seen;

    riscv64 #(
        .reset_pc (tb_reset_pc),
        .trap_pc  (tb_trap_pc)
    ) riscv64_inst (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .dbg_addr         (dbg_addr),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .interrupt_done   (interrupt_done),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .dbg_data         (dbg_data)
    );

    // keyboard answers combinationally while read strobe is up
    assign bus_read_data = bus_read_enable ? key_reg : 64'h0;

    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    endtask

    // compare against the model mid-cycle, all outputs settled
    task automatic check_outputs();
        if (pc !== m_pc) report_mismatch("pc", m_pc, pc);
        if (ir !== m_ir) report_mismatch("ir", m_ir, ir);
        if (heartbeat !== m_hb) report_mismatch("heartbeat", m_hb, heartbeat);
        if (bus_read_enable !== m_read)
            report_mismatch("bus_read_enable", m_read, bus_read_enable);
        if (bus_write_enable !== m_write)
            report_mismatch("bus_write_enable", m_write, bus_write_enable);
        if (interrupt_done !== m_write)
            report_mismatch("interrupt_done", m_write, interrupt_done);
        if (m_read && bus_address !== key_base)
            report_mismatch("bus_address", key_base, bus_address);
        if (m_write && bus_address !== uart_base)
            report_mismatch("bus_address", uart_base, bus_address);
        if (m_write && bus_write_data !== m_wdata)
            report_mismatch("bus_write_data", m_wdata, bus_write_data);
        if (dbg_data !== m_regs[dbg_addr])
            report_mismatch("dbg_data", m_regs[dbg_addr], dbg_data);
    endtask

    // one clock edge of the reference behavior
    task automatic advance_model();
        logic  retire;
        logic  writes;
        logic  key_req;
        xlen_t result;
        retire = !m_write && !m_read && !m_bubble;
        writes = 1'b0;
        result = '0;
        // lui, upper immediate sign-extended from bit 31
        if (m_ir[6:0] == 7'b0110111) begin
            writes = 1'b1;
            result = {{32{m_ir[31]}}, m_ir[31:12], 12'h000};
        end else if (m_ir[6:0] == 7'b0010011 && m_ir[14:12] == 3'b000) begin
            writes = 1'b1;
            result = m_regs[m_ir[19:15]] + {{52{m_ir[31]}}, m_ir[31:20]};
        end
        if (retire && writes && m_ir[11:7] != 5'd0) m_regs[m_ir[11:7]] = result;
        // redirect, stall, bubble or advance
        if (m_write) begin
            m_pc     = tb_trap_pc;
            m_bubble = 1'b1;
        end else if (!m_read) begin
            if (m_bubble) m_bubble = 1'b0;
            else m_pc = m_pc + 32'd4;
        end
        // keyboard copy sequencer
        key_req = (interrupt_vector == 4'd1);
        if (m_read && key_req) m_wdata = key_reg;
        m_write = m_read && key_req;
        m_read  = !m_read && key_req;
        m_ir    = instruction;
        m_hb    = ~m_hb;
    endtask

    // drive 2 ns after the edge, check at negedge, step model at next edge
    task automatic run_cycle(input inst_t instr, input logic [3:0] vec, input reg_idx_t daddr);
        instruction      = instr;
        interrupt_vector = vec;
        dbg_addr         = daddr;
        key_reg          = {$random(seed), $random(seed)};
        @(negedge clk);
        check_outputs();
        last_done = interrupt_done;
        if (bus_read_enable) reads_seen++;
        if (bus_write_enable) writes_seen++;
        @(posedge clk);
        advance_model();
        #2;
    endtask

    function automatic reg_idx_t rand_idx();
        logic [31:0] raw;
        raw = $random(seed);
        return raw[4:0];
    endfunction

    // mix of lui, addi and encodings that must retire as no-ops
    function automatic inst_t random_instr();
        logic [31:0] raw;
        logic [31:0] pick;
        raw  = $random(seed);
        pick = $random(seed);
        case (pick[1:0])
            2'd0: return {raw[31:7], 7'b0110111};
            2'd1, 2'd2: return {raw[31:15], 3'b000, raw[11:7], 7'b0010011};
            default: begin
                // op-imm with another funct3, or a branch
                if (raw[0]) return {raw[31:15], 3'b010, raw[11:7], 7'b0010011};
                return {raw[31:7], 7'b1100011};
            end
        endcase
    endfunction

    task automatic scan_regs();
        for (int i = 0; i < 32; i++) begin
            run_cycle(32'h0, 4'd0, i[4:0]);
        end
    endtask

    task automatic wait_for_done(input int limit);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            run_cycle(random_instr(), 4'd0, rand_idx());
            seen = last_done;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("timeout at t=%0t, interrupt_done never rose", $time);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_base) tests_failed++;
        $display("test %s finished with %0d errors", name, errors - test_base);
        test_base   = errors;
        reads_seen  = 0;
        writes_seen = 0;
    endtask

    initial begin
        seed             = 69330;
        clk              = 1'b0;
        reset            = 1'b0;
        instruction      = '0;
        interrupt_vector = 4'd0;
        dbg_addr         = '0;
        key_reg          = '0;
        errors           = 0;
        test_base        = 0;
        tests_run        = 0;
        tests_failed     = 0;
        reads_seen       = 0;
        writes_seen      = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc     = tb_reset_pc;
        m_ir     = '0;
        m_hb     = 1'b0;
        m_bubble = 1'b0;
        m_read   = 1'b0;
        m_write  = 1'b0;
        m_wdata  = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b1;

        // 1. reset state, registers scanned through the debug port
        if (pc !== tb_reset_pc) report_mismatch("pc", tb_reset_pc, pc);
        if (ir !== 32'h0) report_mismatch("ir", 32'h0, ir);
        if (bus_read_enable !== 1'b0) report_mismatch("bus_read_enable", 0, bus_read_enable);
        if (bus_write_enable !== 1'b0) report_mismatch("bus_write_enable", 0, bus_write_enable);
        if (interrupt_done !== 1'b0) report_mismatch("interrupt_done", 0, interrupt_done);
        scan_regs();
        end_test("reset");

        // 2. raw random words, no interrupt
        repeat (24) run_cycle($random(seed), 4'd0, rand_idx());
        end_test("fetch_pc");

        // 3. execute bursts then full register compare
        repeat (3) begin
            repeat (40) run_cycle(random_instr(), 4'd0, rand_idx());
            scan_regs();
        end
        end_test("lui_addi");

        // 4. vector held two cycles, read then write
        run_cycle(random_instr(), 4'd1, rand_idx());
        run_cycle(random_instr(), 4'd1, rand_idx());
        wait_for_done(8);
        repeat (3) run_cycle(random_instr(), 4'd0, rand_idx());
        if (reads_seen != 1) report_mismatch("bus reads", 1, reads_seen);
        if (writes_seen != 1) report_mismatch("bus writes", 1, writes_seen);
        end_test("irq_copy");

        // 5. lui x7 sits in ir during the bubble and must not retire
        run_cycle(random_instr(), 4'd1, rand_idx());
        run_cycle(random_instr(), 4'd1, rand_idx());
        run_cycle({20'habcde, 5'd7, 7'b0110111}, 4'd0, 5'd7);
        if (last_done !== 1'b1) report_mismatch("interrupt_done", 1, last_done);
        if (pc !== tb_trap_pc) report_mismatch("pc", tb_trap_pc, pc);
        repeat (6) run_cycle(32'h0, 4'd0, 5'd7);
        scan_regs();
        end_test("redirect_bubble");

        // 6. abandoned read, then vectors other than the keyboard
        run_cycle(random_instr(), 4'd1, rand_idx());
        repeat (4) run_cycle(random_instr(), 4'd0, rand_idx());
        if (reads_seen != 1) report_mismatch("bus reads", 1, reads_seen);
        if (writes_seen != 0) report_mismatch("bus writes", 0, writes_seen);
        repeat (20) run_cycle(random_instr(), 4'd2 + 4'({$random(seed)} % 14), rand_idx());
        if (reads_seen != 1) report_mismatch("bus reads", 1, reads_seen);
        if (writes_seen != 0) report_mismatch("bus writes", 0, writes_seen);
        end_test("abandoned_other");

        // bound assertions count into the totals too
        if (riscv64_inst.irq_inst.props_inst.violations != 0) begin
            $display("%0d assertion violations in the sequencer",
                     riscv64_inst.irq_inst.props_inst.violations);
            errors = errors + riscv64_inst.irq_inst.props_inst.violations;
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: riscv64.f
source/rv_isa_pkg.sv
source/rv_bus_pkg.sv
source/rv_regfile.sv
source/rv_irq_sequencer.sv
source/rv_exec_core.sv
source/riscv64.sv
dv/riscv64_props.sv
dv/riscv64_tb.sv

// File: source/riscv64.sv
`timescale 1ns/1ps

module riscv64 #(
    parameter logic [31:0] reset_pc = 32'h0000_0000,
    parameter logic [31:0] trap_pc  = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::inst_t    instruction,
    input  logic [3:0]           interrupt_vector,
    input  rv_isa_pkg::xlen_t    bus_read_data,
    input  rv_isa_pkg::reg_idx_t dbg_addr,
    output logic [31:0]          pc,
    output logic [31:0]          ir,
    output logic                 heartbeat,
    output logic                 interrupt_done,
    output logic [63:0]          bus_address,
    output logic [63:0]          bus_write_data,
    output logic                 bus_write_enable,
    output logic                 bus_read_enable,
    output rv_isa_pkg::xlen_t    dbg_data
);
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    // core to regfile
    rf_write_t rf_wr;
    reg_idx_t  rs1_addr;
    xlen_t     rs1_data;

    // sequencer to core and bus
    bus_req_t  bus_req;
    logic      irq_hold;
    logic      irq_take;

    rv_exec_core #(
        .reset_pc (reset_pc),
        .trap_pc  (trap_pc)
    ) core_inst (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .irq_hold    (irq_hold),
        .irq_take    (irq_take),
        .rs1_data    (rs1_data),
        .rs1_addr    (rs1_addr),
        .rf_wr       (rf_wr),
        .pc          (pc),
        .ir          (ir),
        .heartbeat   (heartbeat)
    );

    // debug port goes straight out
    rv_regfile regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .wr       (rf_wr),
        .rs1_addr (rs1_addr),
        .dbg_addr (dbg_addr),
        .rs1_data (rs1_data),
        .dbg_data (dbg_data)
    );

    rv_irq_sequencer irq_inst (
        .clk              (clk),
        .reset            (reset),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .bus_req          (bus_req),
        .interrupt_done   (interrupt_done),
        .irq_hold         (irq_hold),
        .irq_take         (irq_take)
    );

    // bus request onto the flat pins
    assign bus_address      = bus_req.address;
    assign bus_write_data   = bus_req.write_data;
    assign bus_write_enable = bus_req.write_enable;
    assign bus_read_enable  = bus_req.read_enable;

endmodule

// File: source/rv_bus_pkg.sv
package rv_bus_pkg;

    // simple memory bus request
    // address and write_data are only meaningful while a strobe is high
    // read data comes back combinationally in the same cycle
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        write_enable;
        logic        read_enable;
    } bus_req_t;

    // device map
    // uart transmit register
    localparam logic [63:0] uart_base = 64'h0000_0000_8000_0000;

    // keyboard data register
    localparam logic [63:0] key_base = 64'h0000_0000_8000_0010;

    // interrupt vector codes
    // only the keyboard source is serviced
    localparam logic [3:0] irq_key = 4'd1;

    // all-idle request
    // strobes low, payload don't-care
    localparam bus_req_t bus_idle = '{
        address:      64'h0,
        write_data:   64'h0,
        write_enable: 1'b0,
        read_enable:  1'b0
    };

endpackage

// File: source/rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000,
    parameter logic [31:0] trap_pc  = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_isa_pkg::inst_t     instruction,
    input  logic                  irq_hold,
    input  logic                  irq_take,
    input  rv_isa_pkg::xlen_t     rs1_data,
    output rv_isa_pkg::reg_idx_t  rs1_addr,
    output rv_isa_pkg::rf_write_t rf_wr,
    output logic [31:0]           pc,
    output logic [31:0]           ir,
    output logic                  heartbeat
);
    import rv_isa_pkg::*;

    logic     bubble;
    logic     retire;
    exec_op_e op;
    reg_idx_t rd;
    xlen_t    imm_u;
    xlen_t    imm_i;

    // fetch
    // ir follows instruction with one cycle of lag
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= 32'h0000_0000;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            // free-running toggle, alive indicator
            heartbeat <= ~heartbeat;
        end
    end

    // ir only retires when no interrupt work is pending
    // and the previous cycle was not a redirect
    assign retire = !irq_take && !irq_hold && !bubble;

    // pc and bubble
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc     <= reset_pc;
            bubble <= 1'b0;
        end else begin
            if (irq_take) begin
                // jump to the isr, squash whatever is in ir next cycle
                pc     <= trap_pc;
                bubble <= 1'b1;
            end else if (irq_hold) begin
                // stalled behind the keyboard read
                pc <= pc;
            end else if (bubble) begin
                // ir discarded this cycle
                bubble <= 1'b0;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // instruction fields
    assign rd       = ir[11:7];
    assign rs1_addr = ir[19:15];

    // U-type, upper 20 bits then zeros, sign from bit 31
    assign imm_u = {{32{ir[31]}}, ir[31:12], {imm_u_shift{1'b0}}};

    // I-type, 12 bits sign-extended
    assign imm_i = {{(64 - imm_i_width){ir[31]}}, ir[31:20]};

    // decode
    always_comb begin
        op = nop;
        case (ir[6:0])
            op_lui: begin
                op = lui;
            end
            op_opimm: begin
                // other op-imm functions are not implemented
                if (ir[14:12] == funct3_addi) begin
                    op = addi;
                end
            end
            default: begin
                op = nop;
            end
        endcase
    end

    // execute
    // result goes straight to the regfile, lands at the end of this cycle
    always_comb begin
        rf_wr.we   = retire && (op != nop);
        rf_wr.rd   = rd;
        rf_wr.data = '0;
        case (op)
            lui: begin
                rf_wr.data = imm_u;
            end
            addi: begin
                // wraps modulo 2^64
                rf_wr.data = rs1_data + imm_i;
            end
            default: begin
                rf_wr.data = '0;
            end
        endcase
    end

endmodule

// File: source/rv_irq_sequencer.sv
`timescale 1ns/1ps

module rv_irq_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [3:0]           interrupt_vector,
    input  rv_isa_pkg::xlen_t    bus_read_data,
    output rv_bus_pkg::bus_req_t bus_req,
    output logic                 interrupt_done,
    output logic                 irq_hold,
    output logic                 irq_take
);
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    // idle  nothing outstanding
    // read  keyboard read on the bus this cycle
    typedef enum logic {
        st_idle = 1'b0,
        st_read = 1'b1
    } seq_state_e;

    seq_state_e state;
    logic       key_req;
    logic       write_q;
    xlen_t      addr_q;
    xlen_t      wdata_q;

    // only the keyboard vector is serviced
    assign key_req = (interrupt_vector == irq_key);

    // control state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= st_idle;
            write_q <= 1'b0;
        end else begin
            // write strobe lasts one cycle
            write_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (key_req) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    // vector still up, commit the copy
                    // vector gone, drop the read silently
                    state <= st_idle;
                    if (key_req) begin
                        write_q <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // bus payload
    // held between accesses
    always_ff @(posedge clk) begin
        if ((state == st_idle) && key_req) begin
            addr_q <= key_base;
        end else if ((state == st_read) && key_req) begin
            addr_q  <= uart_base;
            // keyboard byte is valid while the read strobe is up
            wdata_q <= bus_read_data;
        end
    end

    always_comb begin
        bus_req.address      = addr_q;
        bus_req.write_data   = wdata_q;
        bus_req.write_enable = write_q;
        bus_req.read_enable  = (state == st_read);
    end

    // core side
    // hold while the read is in flight, redirect with the write
    assign irq_hold       = (state == st_read);
    assign irq_take       = write_q;
    assign interrupt_done = write_q;

endmodule

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // architectural register width
    typedef logic [63:0] xlen_t;

    // raw 32-bit instruction word
    typedef logic [31:0] inst_t;

    // register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // major opcodes, bits [6:0]
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_opimm = 7'b0010011;

    // funct3 inside op-imm
    localparam logic [2:0] funct3_addi = 3'b000;

    // decode result
    // anything not recognised falls back to nop
    typedef enum logic [1:0] {
        nop  = 2'd0,
        lui  = 2'd1,
        addi = 2'd2
    } exec_op_e;

    // register file write port, core to regfile
    // we   write strobe
    // rd   destination index
    // data value to store
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        xlen_t    data;
    } rf_write_t;

    // sign-extended I-type immediate width
    localparam int imm_i_width = 12;

    // U-type immediate sits in bits [31:12]
    localparam int imm_u_shift = 12;

endpackage

// File: source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_isa_pkg::rf_write_t wr,
    input  rv_isa_pkg::reg_idx_t  rs1_addr,
    input  rv_isa_pkg::reg_idx_t  dbg_addr,
    output rv_isa_pkg::xlen_t     rs1_data,
    output rv_isa_pkg::xlen_t     dbg_data
);
    import rv_isa_pkg::*;

    // 32 x 64-bit storage
    // entry 0 is never written, reads are forced to zero anyway
    xlen_t regs [0:31];

    // single write port
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // writes to x0 are dropped
            if (wr.we && (wr.rd != 5'd0)) begin
                regs[wr.rd] <= wr.data;
            end
        end
    end

    // operand read for the execute stage
    // no bypass, a write lands at the edge and is seen next cycle
    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    // debug read, used by the testbench to scan the whole file
    always_comb begin
        if (dbg_addr == 5'd0) begin
            dbg_data = '0;
        end else begin
            dbg_data = regs[dbg_addr];
        end
    end

endmodule
